//--- design/noc_router_pkg.sv
package noc_router_pkg;

    // router size
    localparam int P         = 5;
    localparam int V         = 2;
    localparam int PV        = P * V;      // input VCs of the whole router
    localparam int BUF_DEPTH = 4;          // flits per input VC

    localparam int FLIT_W = 32;
    localparam int PORT_W = 3;
    localparam int VC_W   = 1;
    localparam int IVC_W  = $clog2(PV);
    localparam int PTR_W  = $clog2(BUF_DEPTH);
    localparam int CRDT_W = $clog2(BUF_DEPTH + 1);

    // flit layout
    localparam int HEAD_BIT = 31;
    localparam int TAIL_BIT = 30;
    localparam int DST_LSB  = 27;          // lookahead out port, 3 bits
    localparam int VC_BIT   = 26;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [V-1:0]      vc_mask_t;
    typedef logic [P-1:0]      port_mask_t;
    typedef logic [PORT_W-1:0] port_idx_t;
    typedef logic [VC_W-1:0]   vc_idx_t;
    typedef logic [CRDT_W-1:0] credit_cnt_t;
    typedef logic [IVC_W-1:0]  ivc_idx_t;  // port * V + vc
    typedef logic [PTR_W-1:0]  buf_ptr_t;

endpackage

//--- design/alloc_if.sv
`timescale 1ns/100ps

interface alloc_if import noc_router_pkg::*; ();

    vc_mask_t  ivc_req;
    port_idx_t head_dst [V];   // lookahead port of each front flit
    vc_mask_t  head_is_head;
    vc_mask_t  head_is_tail;
    vc_mask_t  sw_grant;       // one-hot or zero

    modport port_side (
        output ivc_req,
        output head_dst,
        output head_is_head,
        output head_is_tail,
        input  sw_grant
    );

    modport alloc_side (
        input  ivc_req,
        input  head_dst,
        input  head_is_head,
        input  head_is_tail,
        output sw_grant
    );

endinterface

//--- design/input_port.sv
`timescale 1ns/100ps

module input_port import noc_router_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  flit_t      flit_in,
    input  logic       flit_in_wr,
    output vc_mask_t   credit_out,
    alloc_if.port_side alloc,
    output flit_t      front_flit
);

    flit_t       buffer [V][BUF_DEPTH];
    buf_ptr_t    rd_ptr [V];
    buf_ptr_t    wr_ptr [V];
    credit_cnt_t fill [V];
    flit_t       front [V];
    vc_idx_t     wr_vc;

    assign wr_vc = flit_in[VC_BIT +: VC_W];

    for (genvar v = 0; v < V; v++) begin : g_vc
        logic push;
        logic pop;

        assign push = flit_in_wr && (wr_vc == v);
        assign pop  = alloc.sw_grant[v];

        assign front[v]                = buffer[v][rd_ptr[v]];
        assign alloc.ivc_req[v]        = (fill[v] != '0);
        assign alloc.head_dst[v]       = front[v][DST_LSB +: PORT_W];
        assign alloc.head_is_head[v]   = front[v][HEAD_BIT];
        assign alloc.head_is_tail[v]   = front[v][TAIL_BIT];

        always_ff @(posedge clk) begin
            if (reset) begin
                rd_ptr[v] <= '0;
                wr_ptr[v] <= '0;
                fill[v]   <= '0;
            end else begin
                if (push)
                    wr_ptr[v] <= (wr_ptr[v] == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : wr_ptr[v] + 1'b1;
                if (pop)
                    rd_ptr[v] <= (rd_ptr[v] == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : rd_ptr[v] + 1'b1;
                fill[v] <= fill[v] + push - pop;
            end
        end

        // flit storage
        always_ff @(posedge clk) begin
            if (push)
                buffer[v][wr_ptr[v]] <= flit_in;
        end
    end

    // flit of the VC popped this cycle
    always_comb begin
        front_flit = front[0];
        for (int v = 0; v < V; v++) begin
            if (alloc.sw_grant[v])
                front_flit = front[v];
        end
    end

    // one freed slot per pop, lines up with flit_out_wr
    always_ff @(posedge clk) begin
        if (reset)
            credit_out <= '0;
        else
            credit_out <= alloc.sw_grant;
    end

endmodule

//--- design/vc_sw_allocator.sv
`timescale 1ns/100ps

module vc_sw_allocator import noc_router_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    alloc_if.alloc_side ports [P],
    input  vc_mask_t    ovc_free [P],
    input  vc_mask_t    ovc_has_credit [P],
    output port_mask_t  grant_valid,
    output port_idx_t   grant_src [P],
    output vc_idx_t     grant_ovc [P],
    output port_mask_t  grant_tail,
    output vc_idx_t     ovc_of_ivc [P][V]
);

    vc_mask_t   ivc_req [P];
    port_idx_t  head_dst [P][V];
    vc_mask_t   head_is_head [P];
    vc_mask_t   head_is_tail [P];
    vc_mask_t   sw_grant [P];
    vc_mask_t   held [P];              // input VC owns an output VC
    port_idx_t  dst_held [P][V];
    logic       elig [PV];
    port_idx_t  tgt_port [PV];
    vc_idx_t    tgt_ovc [PV];
    port_mask_t win_valid;
    ivc_idx_t   win_idx [P];
    ivc_idx_t   rr_ptr [P];

    for (genvar i = 0; i < P; i++) begin : g_port
        assign ivc_req[i]        = ports[i].ivc_req;
        assign head_dst[i]       = ports[i].head_dst;
        assign head_is_head[i]   = ports[i].head_is_head;
        assign head_is_tail[i]   = ports[i].head_is_tail;
        assign ports[i].sw_grant = sw_grant[i];
    end

    // target port and output VC of every input VC
    always_comb begin
        int k;
        for (int i = 0; i < P; i++) begin
            for (int v = 0; v < V; v++) begin
                k = i * V + v;
                if (held[i][v]) begin
                    tgt_port[k] = dst_held[i][v];
                    tgt_ovc[k]  = ovc_of_ivc[i][v];
                    elig[k]     = ivc_req[i][v] && ovc_has_credit[tgt_port[k]][tgt_ovc[k]];
                end else begin
                    tgt_port[k] = head_dst[i][v];
                    tgt_ovc[k]  = '0;
                    for (int o = V - 1; o >= 0; o--) begin
                        if (ovc_free[tgt_port[k]][o])
                            tgt_ovc[k] = vc_idx_t'(o);   // lowest free wins
                    end
                    elig[k] = ivc_req[i][v] && head_is_head[i][v] && (tgt_port[k] < P)
                              && (ovc_free[tgt_port[k]] != '0)
                              && ovc_has_credit[tgt_port[k]][tgt_ovc[k]];
                end
            end
        end
    end

    // round robin per output port
    always_comb begin
        int idx;
        for (int o = 0; o < P; o++) begin
            win_valid[o] = 1'b0;
            win_idx[o]   = '0;
            for (int off = 0; off < PV; off++) begin
                idx = (int'(rr_ptr[o]) + off) % PV;
                if (!win_valid[o] && elig[idx] && (tgt_port[idx] == o)) begin
                    win_valid[o] = 1'b1;
                    win_idx[o]   = ivc_idx_t'(idx);
                end
            end
        end
    end

    // one grant per input port, lowest output first
    always_comb begin
        int src;
        int vc;
        for (int i = 0; i < P; i++)
            sw_grant[i] = '0;
        for (int o = 0; o < P; o++) begin
            src            = int'(win_idx[o]) / V;
            vc             = int'(win_idx[o]) % V;
            grant_valid[o] = win_valid[o] && (sw_grant[src] == '0);
            if (grant_valid[o])
                sw_grant[src][vc] = 1'b1;
            grant_src[o]  = port_idx_t'(src);
            grant_ovc[o]  = tgt_ovc[win_idx[o]];
            grant_tail[o] = grant_valid[o] && head_is_tail[src][vc];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int o = 0; o < P; o++)
                rr_ptr[o] <= '0;
            for (int i = 0; i < P; i++)
                held[i] <= '0;
        end else begin
            for (int o = 0; o < P; o++) begin
                if (grant_valid[o])   // step past the winner
                    rr_ptr[o] <= (win_idx[o] == ivc_idx_t'(PV - 1)) ? '0 : win_idx[o] + 1'b1;
            end
            for (int i = 0; i < P; i++) begin
                for (int v = 0; v < V; v++) begin
                    if (sw_grant[i][v])
                        held[i][v] <= !head_is_tail[i][v];
                end
            end
        end
    end

    // route and output VC latched on the head grant
    always_ff @(posedge clk) begin
        for (int i = 0; i < P; i++) begin
            for (int v = 0; v < V; v++) begin
                if (sw_grant[i][v] && !held[i][v]) begin
                    dst_held[i][v]   <= tgt_port[i * V + v];
                    ovc_of_ivc[i][v] <= tgt_ovc[i * V + v];
                end
            end
        end
    end

endmodule

//--- design/output_vc_status.sv
`timescale 1ns/100ps

module output_vc_status import noc_router_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  port_mask_t grant_valid,
    input  vc_idx_t    grant_ovc [P],
    input  port_mask_t grant_tail,
    input  vc_mask_t   credit_in [P],
    output vc_mask_t   ovc_free [P],
    output vc_mask_t   ovc_has_credit [P]
);

    vc_mask_t    allocated [P];
    vc_mask_t    spend [P];         // flit sent on this output VC
    credit_cnt_t credits [P][V];

    always_comb begin
        for (int o = 0; o < P; o++) begin
            for (int v = 0; v < V; v++)
                spend[o][v] = grant_valid[o] && (grant_ovc[o] == v);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int o = 0; o < P; o++) begin
                allocated[o] <= '0;
                for (int v = 0; v < V; v++)
                    credits[o][v] <= credit_cnt_t'(BUF_DEPTH);   // downstream empty
            end
        end else begin
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    // held from head to tail, single flit packets never hold
                    if (spend[o][v])
                        allocated[o][v] <= !grant_tail[o];
                    credits[o][v] <= credits[o][v] + credit_in[o][v] - spend[o][v];
                end
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out
        assign ovc_free[o] = ~allocated[o];
        for (genvar v = 0; v < V; v++) begin : g_vc
            assign ovc_has_credit[o][v] = (credits[o][v] != '0);
        end
    end

endmodule

//--- design/crossbar.sv
`timescale 1ns/100ps

module crossbar import noc_router_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  flit_t      front_flit [P],
    input  port_mask_t grant_valid,
    input  port_idx_t  grant_src [P],
    input  vc_idx_t    grant_ovc [P],
    output flit_t      flit_out [P],
    output port_mask_t flit_out_wr
);

    flit_t sel_flit [P];

    always_comb begin
        for (int o = 0; o < P; o++) begin
            sel_flit[o] = front_flit[grant_src[o]];
            sel_flit[o][VC_BIT +: VC_W] = grant_ovc[o];   // travels on the granted output VC
        end
    end

    // stage 2 output register
    always_ff @(posedge clk) begin
        if (reset)
            flit_out_wr <= '0;
        else
            flit_out_wr <= grant_valid;
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < P; o++) begin
            if (grant_valid[o])
                flit_out[o] <= sel_flit[o];
        end
    end

endmodule

//--- design/credit_release_gen.sv
`timescale 1ns/100ps

module credit_release_gen import noc_router_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic en,
    output logic credit
);

    credit_cnt_t remaining;   // pulses still to send

    assign credit = (remaining != '0);

    always_ff @(posedge clk) begin
        if (reset)
            remaining <= '0;
        else if (en && (remaining <= credit_cnt_t'(1)))
            remaining <= credit_cnt_t'(BUF_DEPTH);   // new burst, back to back with the last
        else if (remaining != '0)
            remaining <= remaining - 1'b1;
    end

endmodule

//--- design/router_two_stage.sv
`timescale 1ns/100ps

module router_two_stage import noc_router_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  flit_t      flit_in [P],
    input  port_mask_t flit_in_wr,
    output vc_mask_t   credit_out [P],
    output flit_t      flit_out [P],
    output port_mask_t flit_out_wr,
    input  vc_mask_t   credit_in [P],
    input  vc_mask_t   credit_release_en [P]
);

    alloc_if alloc_bus [P] ();

    flit_t      front_flit [P];
    vc_mask_t   port_credit [P];
    wire        vc_mask_t release_credit [P];
    vc_mask_t   ovc_free [P];
    vc_mask_t   ovc_has_credit [P];
    port_mask_t grant_valid;
    port_idx_t  grant_src [P];
    vc_idx_t    grant_ovc [P];
    port_mask_t grant_tail;
    vc_idx_t    ovc_of_ivc [P][V];

    for (genvar i = 0; i < P; i++) begin : g_port
        input_port input_port_i (
            .clk        (clk),
            .reset      (reset),
            .flit_in    (flit_in[i]),
            .flit_in_wr (flit_in_wr[i]),
            .credit_out (port_credit[i]),
            .alloc      (alloc_bus[i]),
            .front_flit (front_flit[i])
        );

        // only local endpoints pulse credit_release_en
        for (genvar j = 0; j < V; j++) begin : g_vc
            credit_release_gen credit_release_gen_i (
                .clk    (clk),
                .reset  (reset),
                .en     (credit_release_en[i][j]),
                .credit (release_credit[i][j])
            );
        end

        assign credit_out[i] = port_credit[i] | release_credit[i];
    end

    vc_sw_allocator vc_sw_allocator_i (
        .clk            (clk),
        .reset          (reset),
        .ports          (alloc_bus),
        .ovc_free       (ovc_free),
        .ovc_has_credit (ovc_has_credit),
        .grant_valid    (grant_valid),
        .grant_src      (grant_src),
        .grant_ovc      (grant_ovc),
        .grant_tail     (grant_tail),
        .ovc_of_ivc     (ovc_of_ivc)
    );

    output_vc_status output_vc_status_i (
        .clk            (clk),
        .reset          (reset),
        .grant_valid    (grant_valid),
        .grant_ovc      (grant_ovc),
        .grant_tail     (grant_tail),
        .credit_in      (credit_in),
        .ovc_free       (ovc_free),
        .ovc_has_credit (ovc_has_credit)
    );

    crossbar crossbar_i (
        .clk         (clk),
        .reset       (reset),
        .front_flit  (front_flit),
        .grant_valid (grant_valid),
        .grant_src   (grant_src),
        .grant_ovc   (grant_ovc),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr)
    );

endmodule

//--- bench/router_two_stage_properties.sv
`timescale 1ns/100ps

module router_two_stage_properties import noc_router_pkg::*; (
    input logic       clk,
    input logic       reset,
    input flit_t      flit_in [P],
    input port_mask_t flit_in_wr,
    input vc_mask_t   credit_out [P],
    input flit_t      flit_out [P],
    input port_mask_t flit_out_wr,
    input vc_mask_t   credit_in [P],
    input vc_mask_t   credit_release_en [P]
);

    localparam flit_t VC_MASK = flit_t'(1) << VC_BIT;

    int         errors = 0;       // read by the testbench at the end
    int         in_flight;        // written but not yet on flit_out
    int         open_pkts;        // heads written without their tail
    int         open_delta;
    int         out_used [P][V];  // flits sent minus credits returned
    int         crd_seen [P][V];
    int         crd_exp [P][V];
    int         rel_left [P][V];
    logic       started;
    logic       any_credit;
    logic       any_rel;
    logic       drained;
    logic       lone_now;
    logic       lone_d1;
    logic       lone_d2;
    port_idx_t  lone_dst;
    port_idx_t  lone_dst_d1;
    port_idx_t  lone_dst_d2;
    flit_t      lone_flit;
    flit_t      lone_flit_d1;
    flit_t      lone_flit_d2;
    logic       in_pkt [P][V];
    logic [7:0] cur_tag [P][V];   // packet tag in 15:8, sequence in 7:0
    logic [7:0] next_seq [P][V];

    always_comb begin
        int n_wr;
        n_wr       = 0;
        open_delta = 0;
        lone_dst   = '0;
        lone_flit  = '0;
        any_credit = 1'b0;
        any_rel    = 1'b0;
        drained    = (in_flight == 0);
        for (int i = 0; i < P; i++) begin
            if (flit_in_wr[i]) begin
                n_wr++;
                lone_dst  = flit_in[i][DST_LSB +: PORT_W];
                lone_flit = flit_in[i];
                if (flit_in[i][HEAD_BIT] && !flit_in[i][TAIL_BIT])
                    open_delta++;
                if (flit_in[i][TAIL_BIT] && !flit_in[i][HEAD_BIT])
                    open_delta--;
            end
            any_credit = any_credit || (credit_out[i] != '0);
            any_rel    = any_rel || (credit_release_en[i] != '0);
            for (int v = 0; v < V; v++) begin
                if (rel_left[i][v] != 0)
                    drained = 1'b0;   // release burst still running
            end
        end
        // single-flit packet into an empty router with a credit on output vc 0
        lone_now = (n_wr == 1) && lone_flit[HEAD_BIT] && lone_flit[TAIL_BIT]
                   && (in_flight == 0) && (open_pkts == 0) && (lone_dst < P)
                   && (out_used[lone_dst][0] < BUF_DEPTH);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 0;
            open_pkts <= 0;
            started   <= 1'b0;
            lone_d1   <= 1'b0;
            lone_d2   <= 1'b0;
            for (int i = 0; i < P; i++) begin
                for (int v = 0; v < V; v++) begin
                    out_used[i][v] <= 0;
                    crd_seen[i][v] <= 0;
                    crd_exp[i][v]  <= 0;
                    rel_left[i][v] <= 0;
                    in_pkt[i][v]   <= 1'b0;
                end
            end
        end else begin
            in_flight    <= in_flight + $countones(flit_in_wr) - $countones(flit_out_wr);
            open_pkts    <= open_pkts + open_delta;
            started      <= started || (flit_in_wr != '0) || any_rel;
            lone_d1      <= lone_now;
            lone_d2      <= lone_d1;
            lone_dst_d1  <= lone_dst;
            lone_dst_d2  <= lone_dst_d1;
            lone_flit_d1 <= lone_flit;
            lone_flit_d2 <= lone_flit_d1;
            for (int i = 0; i < P; i++) begin
                for (int v = 0; v < V; v++) begin
                    crd_seen[i][v] <= crd_seen[i][v] + int'(credit_out[i][v]);
                    crd_exp[i][v]  <= crd_exp[i][v]
                                      + int'(flit_in_wr[i] && (flit_in[i][VC_BIT] == v))
                                      + (credit_release_en[i][v] ? BUF_DEPTH : 0);
                    if (credit_release_en[i][v])
                        rel_left[i][v] <= BUF_DEPTH;
                    else if (rel_left[i][v] != 0)
                        rel_left[i][v] <= rel_left[i][v] - 1;
                    out_used[i][v] <= out_used[i][v] - int'(credit_in[i][v])
                                      + int'(flit_out_wr[i] && (flit_out[i][VC_BIT] == v));
                    if (flit_out_wr[i] && (flit_out[i][VC_BIT] == v)) begin
                        in_pkt[i][v]   <= !flit_out[i][TAIL_BIT];
                        cur_tag[i][v]  <= flit_out[i][15:8];
                        next_seq[i][v] <= flit_out[i][7:0] + 8'd1;
                    end
                end
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        !started |-> (flit_out_wr == '0) && !any_credit)
        else begin
            errors++;
            $error("ERR %0t flit_out_wr %b credit_out %b before any input, expected 0",
                   $time, $sampled(flit_out_wr), $sampled(any_credit));
        end

    a_lone: assert property (@(posedge clk) disable iff (reset)
        lone_d2 |-> flit_out_wr[lone_dst_d2]
                    && ((flit_out[lone_dst_d2] & ~VC_MASK) == (lone_flit_d2 & ~VC_MASK)))
        else begin
            errors++;
            $error("ERR %0t flit_out[%0d] got %h (wr %b), expected %h", $time,
                   $sampled(lone_dst_d2), $sampled(flit_out[lone_dst_d2]),
                   $sampled(flit_out_wr[lone_dst_d2]), $sampled(lone_flit_d2));
        end

    for (genvar o = 0; o < P; o++) begin : g_port
        for (genvar v = 0; v < V; v++) begin : g_vc
            logic on_vc;
            assign on_vc = flit_out_wr[o] && (flit_out[o][VC_BIT] == v);

            a_credit: assert property (@(posedge clk) disable iff (reset)
                out_used[o][v] <= BUF_DEPTH)
                else begin
                    errors++;
                    $error("ERR %0t flits in use on output %0d vc %0d: %0d, limit %0d",
                           $time, o, v, $sampled(out_used[o][v]), BUF_DEPTH);
                end

            a_packet: assert property (@(posedge clk) disable iff (reset)
                on_vc |-> (flit_out[o][HEAD_BIT]
                    ? (!in_pkt[o][v] && (flit_out[o][7:0] == 8'd0))
                    : (in_pkt[o][v] && (flit_out[o][15:8] == cur_tag[o][v])
                       && (flit_out[o][7:0] == next_seq[o][v]))))
                else begin
                    errors++;
                    $error("ERR %0t flit_out[%0d] tag/seq %h/%0d, expected %h/%0d", $time, o,
                           $sampled(flit_out[o][15:8]), $sampled(flit_out[o][7:0]),
                           $sampled(cur_tag[o][v]), $sampled(next_seq[o][v]));
                end

            a_count: assert property (@(posedge clk) disable iff (reset)
                drained |-> (crd_seen[o][v] == crd_exp[o][v]))
                else begin
                    errors++;
                    $error("ERR %0t credit_out[%0d][%0d] pulses %0d, expected %0d", $time, o, v,
                           $sampled(crd_seen[o][v]), $sampled(crd_exp[o][v]));
                end

            a_release: assert property (@(posedge clk) disable iff (reset)
                credit_release_en[o][v] |=> credit_out[o][v] [*BUF_DEPTH])
                else begin
                    errors++;
                    $error("release burst on credit_out[%0d][%0d] was not %0d cycles long",
                           o, v, BUF_DEPTH);
                end
        end
    end

endmodule

bind router_two_stage router_two_stage_properties props_i (.*);

//--- bench/router_two_stage_tb.sv
`timescale 1ns/100ps

module router_two_stage_tb import noc_router_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PKTS     = 200;
    localparam int TIMEOUT_CYC  = RESET_CYCLES + NUM_PKTS * 20 + 200;

    logic       clk = 1'b0;
    logic       reset;
    flit_t      flit_in [P];
    port_mask_t flit_in_wr;
    vc_mask_t   credit_out [P];
    flit_t      flit_out [P];
    port_mask_t flit_out_wr;
    vc_mask_t   credit_in [P];
    vc_mask_t   credit_release_en [P];

    int   up_crd [P][V];   // credits held toward the router
    int   owed [P][V];     // downstream credits not yet returned
    int   delay [P][V];
    int   sent;
    int   received;
    logic withhold;

    always #(CLK_PERIOD / 2) clk = ~clk;

    router_two_stage router_two_stage_i (
        .clk               (clk),
        .reset             (reset),
        .flit_in           (flit_in),
        .flit_in_wr        (flit_in_wr),
        .credit_out        (credit_out),
        .flit_out          (flit_out),
        .flit_out_wr       (flit_out_wr),
        .credit_in         (credit_in),
        .credit_release_en (credit_release_en)
    );

    function automatic flit_t make_flit(logic head, logic tail, port_idx_t dst, vc_idx_t vc,
                                        logic [7:0] tag, logic [7:0] seq);
        flit_t f;
        f                       = '0;
        f[HEAD_BIT]             = head;
        f[TAIL_BIT]             = tail;
        f[DST_LSB +: PORT_W]    = dst;
        f[VC_BIT +: VC_W]       = vc;
        f[15:8]                 = tag;
        f[7:0]                  = seq;
        return f;
    endfunction

    function automatic bit settled();
        bit ok;
        ok = (sent == received);
        for (int o = 0; o < P; o++) begin
            for (int v = 0; v < V; v++)
                ok = ok && (owed[o][v] == 0) && (up_crd[o][v] == BUF_DEPTH);
        end
        return ok;
    endfunction

    // one cycle, inputs change after the falling edge
    task automatic step();
        @(negedge clk);
        flit_in_wr = '0;
        for (int o = 0; o < P; o++) begin
            credit_release_en[o] = '0;
            credit_in[o]         = '0;
            if (flit_out_wr[o]) begin
                received++;
                owed[o][flit_out[o][VC_BIT]]++;
            end
            for (int v = 0; v < V; v++) begin
                if (credit_out[o][v] && up_crd[o][v] < BUF_DEPTH)
                    up_crd[o][v]++;   // release credits beyond the buffer are dropped
                if (!withhold && owed[o][v] > 0) begin
                    if (delay[o][v] == 0) begin
                        credit_in[o][v] = 1'b1;
                        owed[o][v]--;
                        delay[o][v] = $urandom_range(5, 0);
                    end else begin
                        delay[o][v]--;
                    end
                end
            end
        end
    endtask

    task automatic put_flit(int port, flit_t f);
        flit_in[port]    = f;
        flit_in_wr[port] = 1'b1;
        up_crd[port][f[VC_BIT]]--;
        sent++;
    endtask

    task automatic wait_drain();
        withhold = 1'b0;
        do
            step();
        while (!settled());
    endtask

    initial begin
        int         tag;
        int         started_pkts;
        int         cyc;
        int         errs;
        bit         busy;
        int         left [P];
        int         seq [P];
        vc_idx_t    pvc [P];
        port_idx_t  pdst [P];
        logic [7:0] ptag [P];

        void'($urandom(95));
        reset        = 1'b1;
        flit_in_wr   = '0;
        withhold     = 1'b0;
        sent         = 0;
        received     = 0;
        tag          = 0;
        started_pkts = 0;
        cyc          = 0;
        for (int i = 0; i < P; i++) begin
            flit_in[i]           = '0;
            credit_in[i]         = '0;
            credit_release_en[i] = '0;
            left[i]              = 0;
            for (int v = 0; v < V; v++) begin
                up_crd[i][v] = BUF_DEPTH;
                owed[i][v]   = 0;
                delay[i][v]  = 0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) step();   // router must stay quiet

        // one lone packet per destination
        for (int d = 0; d < P; d++) begin
            step();
            put_flit((d + 2) % P, make_flit(1'b1, 1'b1, port_idx_t'(d), '0, 8'(tag), 8'd0));
            tag++;
            wait_drain();
        end

        // release burst on every input vc
        for (int i = 0; i < P; i++) begin
            for (int v = 0; v < V; v++) begin
                step();
                credit_release_en[i][v] = 1'b1;
                repeat (BUF_DEPTH + 2) step();
            end
        end

        // random traffic, downstream credits held back in some windows
        do begin
            step();
            cyc++;
            withhold = (cyc % 128) >= 96;
            busy     = 1'b0;
            for (int i = 0; i < P; i++) begin
                if (left[i] == 0 && started_pkts < NUM_PKTS && $urandom_range(1, 0) == 1) begin
                    left[i] = $urandom_range(3, 1);
                    seq[i]  = 0;
                    pvc[i]  = vc_idx_t'($urandom_range(V - 1, 0));
                    pdst[i] = port_idx_t'($urandom_range(P - 1, 0));
                    ptag[i] = 8'(tag);
                    tag++;
                    started_pkts++;
                end
                if (left[i] > 0 && up_crd[i][pvc[i]] > 0 && $urandom_range(3, 0) != 0) begin
                    put_flit(i, make_flit(seq[i] == 0, left[i] == 1, pdst[i], pvc[i],
                                          ptag[i], 8'(seq[i])));
                    seq[i]++;
                    left[i]--;
                end
                busy = busy || (left[i] > 0);
            end
        end while (started_pkts < NUM_PKTS || busy);
        wait_drain();

        errs = router_two_stage_i.props_i.errors;
        $display("closing: %0d assertion errors, %0d flits sent, %0d received",
                 errs, sent, received);
        if (errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, traffic did not drain", TIMEOUT_CYC);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- router_two_stage.f
design/noc_router_pkg.sv
design/alloc_if.sv
design/input_port.sv
design/vc_sw_allocator.sv
design/output_vc_status.sv
design/crossbar.sv
design/credit_release_gen.sv
design/router_two_stage.sv
bench/router_two_stage_properties.sv
bench/router_two_stage_tb.sv

//--- Bender.yml
package:
  name: router_two_stage

sources:
  - files:
      - design/noc_router_pkg.sv
      - design/alloc_if.sv
      - design/input_port.sv
      - design/vc_sw_allocator.sv
      - design/output_vc_status.sv
      - design/crossbar.sv
      - design/credit_release_gen.sv
      - design/router_two_stage.sv
  - target: test
    files:
      - bench/router_two_stage_properties.sv
      - bench/router_two_stage_tb.sv
